// ==== hw/mutex_pkg.sv ====
// mutex bank package: ID and index widths, error and prescale codes, request and event structs
`default_nettype none

package mutex_pkg;

    // ================================================
    // widths
    // ================================================
    localparam int SWID_W = 31;
    localparam int HWID_W = 6;
    // index wide enough for up to 32 mutexes
    localparam int IDX_W  = 5;

    // ================================================
    // codes
    // ================================================
    typedef enum logic [2:0] {
        ERR_NONE    = 3'd0,
        ERR_TIMEOUT = 3'd6,
        ERR_PERM    = 3'd7
    } err_code_t;

    typedef enum logic [1:0] {
        PRE_1   = 2'd0,
        PRE_16  = 2'd1,
        PRE_256 = 2'd2,
        PRE_OFF = 2'd3
    } prescale_t;

    // ================================================
    // structs
    // ================================================
    // one access from an agent, lock=1 acquires and lock=0 releases
    typedef struct packed {
        logic [IDX_W-1:0]  idx;
        logic              wr;
        logic              rd;
        logic              lock;
        logic [SWID_W-1:0] swid;
        logic [HWID_W-1:0] hwid;
    } mutex_req_t;

    // refused release, IDs are from the offending request
    typedef struct packed {
        logic              valid;
        logic [IDX_W-1:0]  idx;
        logic [SWID_W-1:0] swid;
        logic [HWID_W-1:0] hwid;
    } perm_err_t;

    typedef struct packed {
        err_code_t         code;
        logic              multi;
        logic [HWID_W-1:0] hwid;
        logic [SWID_W-1:0] swid;
        logic [IDX_W-1:0]  idx;
    } err_log_t;

endpackage

`default_nettype wire

// ==== hw/mutex_lock_table.sv ====
// lock table: lock bits, owner IDs, release permission check, acquire/release and readback
`timescale 1ns/1ps
`default_nettype none

module mutex_lock_table #(
    parameter int MUTEX_COUNT = 8
) (
    input  logic                              clkclk,
    input  logic                              sysreset_n,
    input  mutex_pkg::mutex_req_t             req,
    input  logic [mutex_pkg::HWID_W-1:0]      sup_hwid,
    output logic [MUTEX_COUNT-1:0]            locked,
    output logic [MUTEX_COUNT-1:0]            write_ok,
    output mutex_pkg::perm_err_t              perm_err,
    output logic                              rd_lock,
    output logic [mutex_pkg::SWID_W-1:0]      rd_swid
);

    logic [MUTEX_COUNT-1:0]                             lock_q;
    logic [MUTEX_COUNT-1:0][mutex_pkg::SWID_W-1:0]      owner_swid_q;
    logic [MUTEX_COUNT-1:0][mutex_pkg::HWID_W-1:0]      owner_hwid_q;

    logic [MUTEX_COUNT-1:0]        sel;
    logic                          sel_lock;
    logic [mutex_pkg::SWID_W-1:0]  sel_swid;
    logic [mutex_pkg::HWID_W-1:0]  sel_hwid;
    logic                          is_owner;
    logic                          is_sup;
    logic                          refuse;

    // ================================================
    // decode and permission check
    // ================================================
    // idx beyond MUTEX_COUNT selects nothing, so the request is ignored
    always_comb begin
        sel      = '0;
        sel_lock = 1'b0;
        sel_swid = '0;
        sel_hwid = '0;
        for (int ii = 0; ii < MUTEX_COUNT; ii++) begin
            sel[ii] = (req.idx == mutex_pkg::IDX_W'(ii));
            if (sel[ii]) begin
                sel_lock = lock_q[ii];
                sel_swid = owner_swid_q[ii];
                sel_hwid = owner_hwid_q[ii];
            end
        end
    end

    assign is_owner = (req.swid == sel_swid) && (req.hwid == sel_hwid);
    assign is_sup   = (req.hwid == sup_hwid);

    // only a release of a held lock can be refused
    assign refuse = req.wr && !req.lock && sel_lock && !is_owner && !is_sup;

    // acquire of a held lock is accepted too but leaves the owner alone
    assign write_ok = (req.wr && !refuse) ? sel : '0;

    always_comb begin
        perm_err.valid = refuse;
        perm_err.idx   = req.idx;
        perm_err.swid  = req.swid;
        perm_err.hwid  = req.hwid;
    end

    // ================================================
    // lock state
    // ================================================
    always_ff @(posedge clkclk or negedge sysreset_n) begin
        if (!sysreset_n) begin
            lock_q <= '0;
        end else begin
            for (int ii = 0; ii < MUTEX_COUNT; ii++) begin
                if (write_ok[ii]) begin
                    lock_q[ii] <= req.lock;
                end
            end
        end
    end

    // owner IDs only matter while the lock bit is set
    always_ff @(posedge clkclk) begin
        for (int ii = 0; ii < MUTEX_COUNT; ii++) begin
            if (write_ok[ii]) begin
                if (req.lock && !lock_q[ii]) begin
                    owner_swid_q[ii] <= req.swid;
                    owner_hwid_q[ii] <= req.hwid;
                end else if (!req.lock) begin
                    owner_swid_q[ii] <= '0;
                end
            end
        end
    end

    assign locked = lock_q;

    // ================================================
    // readback
    // ================================================
    // reads the registered state, so a same-cycle write is not yet visible
    assign rd_lock = req.rd && sel_lock;
    assign rd_swid = rd_lock ? sel_swid : '0;

endmodule

`default_nettype wire

// ==== hw/mutex_timeout_watch.sv ====
// timeout watch: shared prescaler, per-lock hold counters and lowest expired index
`timescale 1ns/1ps
`default_nettype none

module mutex_timeout_watch #(
    parameter int MUTEX_COUNT   = 8,
    parameter int TIMEOUT_WIDTH = 8
) (
    input  logic                            clkclk,
    input  logic                            sysreset_n,
    input  logic [MUTEX_COUNT-1:0]          locked,
    input  logic [MUTEX_COUNT-1:0]          write_ok,
    input  logic                            timeout_taken,
    input  mutex_pkg::prescale_t            tmo_prescale,
    input  logic [TIMEOUT_WIDTH-1:0]        tmo_compare,
    output logic                            expired,
    output logic [mutex_pkg::IDX_W-1:0]     expired_idx
);

    localparam int PRE_W = 8;

    logic [PRE_W-1:0]                           pre_cnt_q;
    logic                                       run;
    logic                                       tick;
    logic [MUTEX_COUNT-1:0][TIMEOUT_WIDTH-1:0]  cnt_q;
    logic [MUTEX_COUNT-1:0]                     at_cmp;

    // ================================================
    // prescaler
    // ================================================
    // compare of zero turns the whole watch off
    assign run = (|locked) && (|tmo_compare);

    always_ff @(posedge clkclk or negedge sysreset_n) begin
        if (!sysreset_n) begin
            pre_cnt_q <= '0;
        end else if (run) begin
            pre_cnt_q <= pre_cnt_q + PRE_W'(1);
        end
    end

    always_comb begin
        unique case (tmo_prescale)
            mutex_pkg::PRE_1:   tick = run;
            mutex_pkg::PRE_16:  tick = run && (&pre_cnt_q[3:0]);
            mutex_pkg::PRE_256: tick = run && (&pre_cnt_q);
            mutex_pkg::PRE_OFF: tick = 1'b0;
            default:            tick = 1'b0;
        endcase
    end

    // ================================================
    // hold counters
    // ================================================
    always_comb begin
        for (int ii = 0; ii < MUTEX_COUNT; ii++) begin
            at_cmp[ii] = (|tmo_compare) && (cnt_q[ii] == tmo_compare);
        end
    end

    // a counter parks at compare until the log takes it or the lock is rewritten
    always_ff @(posedge clkclk or negedge sysreset_n) begin
        if (!sysreset_n) begin
            cnt_q <= '0;
        end else begin
            for (int ii = 0; ii < MUTEX_COUNT; ii++) begin
                if (write_ok[ii]) begin
                    cnt_q[ii] <= '0;
                end else if (timeout_taken && (expired_idx == mutex_pkg::IDX_W'(ii))) begin
                    cnt_q[ii] <= '0;
                end else if (locked[ii] && tick && !at_cmp[ii]) begin
                    cnt_q[ii] <= cnt_q[ii] + TIMEOUT_WIDTH'(1);
                end
            end
        end
    end

    // ================================================
    // expiry
    // ================================================
    assign expired = |at_cmp;

    // scan downward so the lowest index wins
    always_comb begin
        expired_idx = '0;
        for (int ii = MUTEX_COUNT - 1; ii >= 0; ii--) begin
            if (at_cmp[ii]) begin
                expired_idx = mutex_pkg::IDX_W'(ii);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/mutex_error_log.sv ====
// error log: first-error capture with timeout priority, multi flag and interrupt
`timescale 1ns/1ps
`default_nettype none

module mutex_error_log (
    input  logic                            clkclk,
    input  logic                            sysreset_n,
    input  mutex_pkg::perm_err_t            perm_err,
    input  logic                            expired,
    input  logic [mutex_pkg::IDX_W-1:0]     expired_idx,
    input  logic                            err_clear,
    output logic                            timeout_taken,
    output mutex_pkg::err_log_t             err_log,
    output logic                            err_irq
);

    mutex_pkg::err_log_t  log_q;
    mutex_pkg::err_log_t  base;
    mutex_pkg::err_log_t  log_d;
    logic                 empty;
    logic                 take_tmo;
    logic                 take_perm;

    // ================================================
    // next log contents
    // ================================================
    // clear empties the log first, so an error in the clear cycle is still caught
    always_comb begin
        if (err_clear) begin
            base = '0;
        end else begin
            base = log_q;
        end
        empty = (base.code == mutex_pkg::ERR_NONE);
    end

    // timeout beats a permission error in the same cycle
    assign take_tmo  = empty && expired;
    assign take_perm = empty && !expired && perm_err.valid;

    always_comb begin
        log_d = base;
        if (take_tmo) begin
            // IDs are left as they were, only the index is new
            log_d.code  = mutex_pkg::ERR_TIMEOUT;
            log_d.idx   = expired_idx;
            log_d.multi = perm_err.valid;
        end else if (take_perm) begin
            log_d.code  = mutex_pkg::ERR_PERM;
            log_d.multi = 1'b0;
            log_d.hwid  = perm_err.hwid;
            log_d.swid  = perm_err.swid;
            log_d.idx   = perm_err.idx;
        end else if (!empty && (perm_err.valid || expired)) begin
            log_d.multi = 1'b1;
        end
    end

    // resets the hold counter of the lock just logged
    assign timeout_taken = take_tmo;

    // ================================================
    // registers
    // ================================================
    always_ff @(posedge clkclk or negedge sysreset_n) begin
        if (!sysreset_n) begin
            log_q <= '0;
        end else begin
            log_q <= log_d;
        end
    end

    // irq follows the stored code one edge later
    always_ff @(posedge clkclk or negedge sysreset_n) begin
        if (!sysreset_n) begin
            err_irq <= 1'b0;
        end else begin
            err_irq <= (log_q.code != mutex_pkg::ERR_NONE);
        end
    end

    assign err_log = log_q;

endmodule

`default_nettype wire

// ==== hw/mutex_top.sv ====
// mutex bank top level: lock table, timeout watch and error log
`timescale 1ns/1ps
`default_nettype none

module mutex_top #(
    parameter int MUTEX_COUNT   = 8,
    parameter int TIMEOUT_WIDTH = 8
) (
    input  logic                            clkclk,
    input  logic                            sysreset_n,
    input  mutex_pkg::mutex_req_t           req,
    input  logic [mutex_pkg::HWID_W-1:0]    sup_hwid,
    input  mutex_pkg::prescale_t            tmo_prescale,
    input  logic [TIMEOUT_WIDTH-1:0]        tmo_compare,
    input  logic                            err_clear,
    output logic                            rd_lock,
    output logic [mutex_pkg::SWID_W-1:0]    rd_swid,
    output mutex_pkg::err_log_t             err_log,
    output logic                            err_irq
);

    logic [MUTEX_COUNT-1:0]         locked;
    logic [MUTEX_COUNT-1:0]         write_ok;
    mutex_pkg::perm_err_t           perm_err;
    logic                           expired;
    logic [mutex_pkg::IDX_W-1:0]    expired_idx;
    logic                           timeout_taken;

    // ================================================
    // lock table
    // ================================================
    mutex_lock_table #(
        .MUTEX_COUNT (MUTEX_COUNT)
    ) u_lock_table (
        .clkclk     (clkclk),
        .sysreset_n (sysreset_n),
        .req        (req),
        .sup_hwid   (sup_hwid),
        .locked     (locked),
        .write_ok   (write_ok),
        .perm_err   (perm_err),
        .rd_lock    (rd_lock),
        .rd_swid    (rd_swid)
    );

    // ================================================
    // timeout watch, runs beside the lock table
    // ================================================
    mutex_timeout_watch #(
        .MUTEX_COUNT   (MUTEX_COUNT),
        .TIMEOUT_WIDTH (TIMEOUT_WIDTH)
    ) u_timeout_watch (
        .clkclk        (clkclk),
        .sysreset_n    (sysreset_n),
        .locked        (locked),
        .write_ok      (write_ok),
        .timeout_taken (timeout_taken),
        .tmo_prescale  (tmo_prescale),
        .tmo_compare   (tmo_compare),
        .expired       (expired),
        .expired_idx   (expired_idx)
    );

    // ================================================
    // error log merges both error sources
    // ================================================
    mutex_error_log u_error_log (
        .clkclk        (clkclk),
        .sysreset_n    (sysreset_n),
        .perm_err      (perm_err),
        .expired       (expired),
        .expired_idx   (expired_idx),
        .err_clear     (err_clear),
        .timeout_taken (timeout_taken),
        .err_log       (err_log),
        .err_irq       (err_irq)
    );

endmodule

`default_nettype wire

// ==== sim/mutex_tb.sv ====
// mutex bank testbench: clock, reset, stimulus, reference model and assertion checks
`timescale 1ns/1ps
`default_nettype none

module mutex_tb;

    localparam int MUTEX_COUNT   = 8;
    localparam int TIMEOUT_WIDTH = 8;

    logic                             clkclk;
    logic                             sysreset_n;
    mutex_pkg::mutex_req_t            req;
    logic [mutex_pkg::HWID_W-1:0]     sup_hwid;
    mutex_pkg::prescale_t             tmo_prescale;
    logic [TIMEOUT_WIDTH-1:0]         tmo_compare;
    logic                             err_clear;
    logic                             rd_lock;
    logic [mutex_pkg::SWID_W-1:0]     rd_swid;
    mutex_pkg::err_log_t              err_log;
    logic                             err_irq;

    // reference model of the lock table and the log
    logic [MUTEX_COUNT-1:0]           ref_lock;
    logic [mutex_pkg::SWID_W-1:0]     ref_swid [MUTEX_COUNT];
    logic [mutex_pkg::HWID_W-1:0]     ref_hwid [MUTEX_COUNT];
    mutex_pkg::err_log_t              exp_log;

    integer                           seed;
    logic [31:0]                      rnd;
    logic [mutex_pkg::SWID_W-1:0]     swid_a;
    logic [mutex_pkg::SWID_W-1:0]     swid_b;
    logic [mutex_pkg::HWID_W-1:0]     hwid_a;
    logic [mutex_pkg::HWID_W-1:0]     hwid_b;

    mutex_top #(
        .MUTEX_COUNT   (MUTEX_COUNT),
        .TIMEOUT_WIDTH (TIMEOUT_WIDTH)
    ) u_mutex_top (
        .clkclk       (clkclk),
        .sysreset_n   (sysreset_n),
        .req          (req),
        .sup_hwid     (sup_hwid),
        .tmo_prescale (tmo_prescale),
        .tmo_compare  (tmo_compare),
        .err_clear    (err_clear),
        .rd_lock      (rd_lock),
        .rd_swid      (rd_swid),
        .err_log      (err_log),
        .err_irq      (err_irq)
    );

    initial begin
        clkclk = 1'b0;
        forever #50 clkclk = ~clkclk;
    end

    // ================================================
    // checking helpers
    // ================================================
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERR t=%0t %s exp=%0h got=%0h", $time, name, exp, got);
            $display("=== FAIL ===");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic give_up(input string what);
        $display("gave up waiting: %s", what);
        $display("=== FAIL ===");
        $fatal(1, "%s", what);
    endtask

    // inputs change 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge clkclk);
        #10;
    endtask

    task automatic check_log();
        check_value("err_log", 64'(err_log), 64'(exp_log));
    endtask

    task automatic check_log_empty();
        check_value("err_log.code", 64'(err_log.code), 64'(mutex_pkg::ERR_NONE));
    endtask

    task automatic wait_for_log(input int max_cycles);
        int n;
        n = 0;
        while (err_log.code == mutex_pkg::ERR_NONE) begin
            if (n >= max_cycles) begin
                give_up("no error was logged in time");
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    // ================================================
    // reference model and stimulus
    // ================================================
    task automatic model_write(input int idx, input logic lock,
                               input logic [mutex_pkg::SWID_W-1:0] swid,
                               input logic [mutex_pkg::HWID_W-1:0] hwid);
        logic owner;
        owner = (swid == ref_swid[idx]) && (hwid == ref_hwid[idx]);
        if (!lock && ref_lock[idx] && !owner && (hwid != sup_hwid)) begin
            if (exp_log.code == mutex_pkg::ERR_NONE) begin
                exp_log.code  = mutex_pkg::ERR_PERM;
                exp_log.multi = 1'b0;
                exp_log.hwid  = hwid;
                exp_log.swid  = swid;
                exp_log.idx   = mutex_pkg::IDX_W'(idx);
            end else begin
                exp_log.multi = 1'b1;
            end
        end else if (lock) begin
            if (!ref_lock[idx]) begin
                ref_lock[idx] = 1'b1;
                ref_swid[idx] = swid;
                ref_hwid[idx] = hwid;
            end
        end else begin
            ref_lock[idx] = 1'b0;
            ref_swid[idx] = '0;
        end
    endtask

    task automatic write_req(input int idx, input logic lock,
                             input logic [mutex_pkg::SWID_W-1:0] swid,
                             input logic [mutex_pkg::HWID_W-1:0] hwid);
        req      = '0;
        req.idx  = mutex_pkg::IDX_W'(idx);
        req.wr   = 1'b1;
        req.lock = lock;
        req.swid = swid;
        req.hwid = hwid;
        model_write(idx, lock, swid, hwid);
        next_cycle();
        req = '0;
    endtask

    task automatic read_check(input int idx);
        req     = '0;
        req.idx = mutex_pkg::IDX_W'(idx);
        req.rd  = 1'b1;
        #1;
        check_value("rd_lock", 64'(rd_lock), 64'(ref_lock[idx]));
        check_value("rd_swid", 64'(rd_swid), ref_lock[idx] ? 64'(ref_swid[idx]) : 64'd0);
        next_cycle();
        req = '0;
    endtask

    task automatic pulse_clear();
        err_clear = 1'b1;
        next_cycle();
        err_clear = 1'b0;
        exp_log   = '0;
    endtask

    // ================================================
    // test sequence
    // ================================================
    initial begin
        int k;
        seed         = 32'h769b;
        req          = '0;
        sup_hwid     = 6'h3f;
        tmo_prescale = mutex_pkg::PRE_1;
        tmo_compare  = '0;
        err_clear    = 1'b0;
        sysreset_n   = 1'b0;
        ref_lock     = '0;
        exp_log      = '0;
        for (k = 0; k < MUTEX_COUNT; k++) begin
            ref_swid[k] = '0;
            ref_hwid[k] = '0;
        end
        rnd    = $random(seed);
        swid_a = rnd[30:0];
        swid_b = swid_a ^ 31'h1;
        rnd    = $random(seed);
        // agent IDs stay below the supervisor ID
        hwid_a = {1'b0, rnd[4:0]};
        hwid_b = hwid_a ^ 6'h01;

        repeat (2) next_cycle();
        sysreset_n = 1'b1;
        next_cycle();
        check_log();
        check_value("err_irq", 64'(err_irq), 64'd0);
        for (k = 0; k < MUTEX_COUNT; k++) begin
            read_check(k);
        end

        // acquire, read, acquire by another agent, read of a free lock
        write_req(1, 1'b1, swid_a, hwid_a);
        read_check(1);
        write_req(1, 1'b1, swid_b, hwid_b);
        read_check(1);
        read_check(4);

        // owner release and supervisor release
        write_req(1, 1'b0, swid_a, hwid_a);
        read_check(1);
        write_req(6, 1'b1, swid_b, hwid_b);
        write_req(6, 1'b0, swid_a, sup_hwid);
        read_check(6);
        check_log();
        check_value("err_irq", 64'(err_irq), 64'd0);

        // refused release with a wrong software ID
        write_req(2, 1'b1, swid_a, hwid_a);
        write_req(2, 1'b0, swid_b, hwid_a);
        check_log();
        check_value("err_irq", 64'(err_irq), 64'd0);
        next_cycle();
        check_value("err_irq", 64'(err_irq), 64'd1);
        read_check(2);

        // second bad release on another lock with a wrong hardware ID only sets multi
        write_req(5, 1'b1, swid_a, hwid_a);
        write_req(5, 1'b0, swid_a, hwid_b);
        check_log();
        pulse_clear();
        check_log();
        check_value("err_irq", 64'(err_irq), 64'd1);
        next_cycle();
        check_value("err_irq", 64'(err_irq), 64'd0);

        // free everything so only the lock under test can expire
        for (k = 0; k < MUTEX_COUNT; k++) begin
            write_req(k, 1'b0, '0, sup_hwid);
        end
        check_log();

        // timeout with PRE_1 and compare 5
        tmo_compare = 8'd5;
        write_req(3, 1'b1, swid_a, hwid_a);
        wait_for_log(20);
        check_value("err_log.code", 64'(err_log.code), 64'(mutex_pkg::ERR_TIMEOUT));
        check_value("err_log.idx", 64'(err_log.idx), 64'd3);
        check_value("err_log.multi", 64'(err_log.multi), 64'd0);
        write_req(3, 1'b0, swid_a, hwid_a);
        pulse_clear();
        check_log();

        // reacquire before expiry restarts the count
        write_req(2, 1'b1, swid_b, hwid_b);
        repeat (2) next_cycle();
        write_req(2, 1'b1, swid_b, hwid_b);
        for (k = 0; k < 5; k++) begin
            next_cycle();
            check_log_empty();
        end
        wait_for_log(10);
        check_value("err_log.code", 64'(err_log.code), 64'(mutex_pkg::ERR_TIMEOUT));
        check_value("err_log.idx", 64'(err_log.idx), 64'd2);
        write_req(2, 1'b0, swid_b, hwid_b);
        pulse_clear();
        check_log();

        // compare 0 and then PRE_OFF keep the watch silent
        tmo_compare = '0;
        write_req(4, 1'b1, swid_a, hwid_a);
        for (k = 0; k < 600; k++) begin
            next_cycle();
            check_log_empty();
        end
        tmo_compare  = 8'd5;
        tmo_prescale = mutex_pkg::PRE_OFF;
        for (k = 0; k < 600; k++) begin
            next_cycle();
            check_log_empty();
        end
        write_req(4, 1'b0, swid_a, hwid_a);
        read_check(4);
        check_log();
        check_value("err_irq", 64'(err_irq), 64'd0);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/mutex_pkg.sv
hw/mutex_lock_table.sv
hw/mutex_timeout_watch.sv
hw/mutex_error_log.sv
hw/mutex_top.sv
sim/mutex_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the mutex bank testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module mutex_tb -Mdir obj_dir \
    && ./obj_dir/Vmutex_tb | tee sim.log
grep -q "=== PASS ===" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
